/* gb_cpu_bus.f */
rtl/gb_bus_pkg.sv
rtl/mcycle_if.sv
rtl/bus_cycle_unit.sv
rtl/int_dispatch.sv
rtl/power_ctrl.sv
rtl/gb_cpu_bus.sv
tb/tb_gb_cpu_bus.sv

/* Bender.yml */
package:
  name: gb_cpu_bus

sources:
  # Design, package first
  - files:
      - rtl/gb_bus_pkg.sv
      - rtl/mcycle_if.sv
      - rtl/bus_cycle_unit.sv
      - rtl/int_dispatch.sv
      - rtl/power_ctrl.sv
      - rtl/gb_cpu_bus.sv

  # Simulation only
  - target: test
    files:
      - tb/tb_gb_cpu_bus.sv

/* tb/tb_gb_cpu_bus.sv */
module tb_gb_cpu_bus;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int          TIMEOUT_CYCLES = 2000;   // Six tests of ~60 cycles each
    localparam logic [31:0] SEED           = 32'h9632_10b2;

    logic                 clk;
    logic                 rst;
    gb_bus_pkg::bus_op_e  cmd_op;
    logic [15:0]          cmd_addr;
    logic [7:0]           cmd_data;
    logic                 cmd_high;
    logic                 cmd_req;
    logic [7:0]           opcode;
    logic [7:0]           rdata;
    logic [7:0]           din;
    logic [15:0]          a;
    logic [7:0]           dout;
    logic                 rd;
    logic                 wr;
    logic                 phi;
    logic [4:0]           int_en;
    logic [4:0]           int_flags_in;
    logic                 ime;
    logic                 int_ack;
    logic [4:0]           int_flags_out;
    logic                 int_dispatch;
    logic [15:0]          int_vector;
    logic                 halt_req;
    logic                 stop_req;
    logic [7:0]           key_in;
    logic                 done;
    int                   cycle_count = 0;

    gb_cpu_bus u_gb_cpu_bus (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: run exceeded %0d clock cycles", TIMEOUT_CYCLES);
            $display("Test failed");
            $fatal(1);
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("mismatch %s: got 0x%0h, expected 0x%0h", name, actual, expected);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    // All driving and sampling happens 1 ns past the edge
    task automatic next_clock;
        @(posedge clk);
        #1;
    endtask

    task automatic wait_cmd_req;
        next_clock();
        while (cmd_req !== 1'b1) next_clock();
    endtask

    function automatic logic [4:0] lowest_bit(input logic [4:0] v);
        return v & (~v + 5'd1);   // Isolate lowest set bit
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_reset_state;
        #1;
        check_value("a", a, 0);
        check_value("rd", rd, 0);
        check_value("wr", wr, 0);
        check_value("dout", dout, 0);
        check_value("phi", phi, 1);
        check_value("opcode", opcode, 0);
        check_value("rdata", rdata, 0);
        check_value("int_dispatch", int_dispatch, 0);
        check_value("done", done, 0);
        check_value("cmd_req", cmd_req, 1);
        for (int i = 1; i <= 4; i++) begin
            next_clock();
            check_value("cmd_req", cmd_req, i == 4);
        end
    endtask

    task automatic run_fetch;
        logic [15:0] addr;
        logic [7:0]  val;
        addr = 16'($urandom);
        val  = 8'($urandom);
        wait_cmd_req();
        cmd_op   = gb_bus_pkg::BUS_FETCH;
        cmd_addr = addr;
        next_clock();                       // T1
        cmd_op = gb_bus_pkg::BUS_IDLE;
        check_value("a", a, addr);
        check_value("rd", rd, 1);
        check_value("phi", phi, 1);
        din = val;
        next_clock();                       // T2
        check_value("rd", rd, 1);
        next_clock();                       // T3
        check_value("opcode", opcode, val);
        check_value("rd", rd, 0);
        check_value("phi", phi, 0);
    endtask

    task automatic write_high_page;
        logic [15:0] addr;
        logic [7:0]  val;
        addr = 16'($urandom);
        val  = 8'($urandom);
        wait_cmd_req();
        cmd_op   = gb_bus_pkg::BUS_WRITE;
        cmd_addr = addr;
        cmd_high = 1'b1;
        cmd_data = val;
        next_clock();
        cmd_op   = gb_bus_pkg::BUS_IDLE;
        cmd_high = 1'b0;
        check_value("a", a, {8'hFF, addr[7:0]});
        check_value("rd", rd, 0);
        check_value("wr", wr, 0);
        next_clock();
        check_value("wr", wr, 0);
        next_clock();                       // T3 write strobe
        check_value("wr", wr, 1);
        check_value("dout", dout, val);
        next_clock();                       // Next T0
        check_value("wr", wr, 0);
        check_value("dout", dout, 0);
        check_value("cmd_req", cmd_req, 1);
    endtask

    task automatic read_cycle;
        logic [15:0] addr;
        logic [7:0]  val;
        addr = 16'($urandom);
        val  = 8'($urandom);
        wait_cmd_req();
        cmd_op   = gb_bus_pkg::BUS_READ;
        cmd_addr = addr;
        next_clock();
        cmd_op = gb_bus_pkg::BUS_IDLE;
        check_value("a", a, addr);
        check_value("rd", rd, 1);
        check_value("wr", wr, 0);
        din = val;
        next_clock();
        check_value("wr", wr, 0);
        next_clock();
        check_value("rdata", rdata, val);
        check_value("rd", rd, 0);
        check_value("wr", wr, 0);
    endtask

    task automatic dispatch_interrupts;
        logic [4:0] flags;
        logic [4:0] en;
        flags = 5'b11100;
        en    = 5'b11010;                   // Bits 3 and 4 pending
        wait_cmd_req();
        ime          = 1'b1;
        int_en       = en;
        int_flags_in = flags;
        cmd_op       = gb_bus_pkg::BUS_FETCH;
        cmd_addr     = 16'($urandom);
        #1;
        check_value("int_vector", int_vector, 16'h0058);   // 0040 + 8 * 3
        check_value("int_flags_out", int_flags_out, flags);
        next_clock();
        cmd_op = gb_bus_pkg::BUS_IDLE;
        check_value("int_dispatch", int_dispatch, 0);
        next_clock();
        check_value("int_dispatch", int_dispatch, 0);
        next_clock();                       // Set by the fetch boundary
        check_value("int_dispatch", int_dispatch, 1);
        int_ack = 1'b1;
        #1;
        check_value("int_flags_out", int_flags_out, flags & ~lowest_bit(flags & en));
        next_clock();
        int_ack = 1'b0;
        #1;
        check_value("int_dispatch", int_dispatch, 0);
        check_value("int_flags_out", int_flags_out, flags);

        // Same requests with IME off
        wait_cmd_req();
        ime      = 1'b0;
        cmd_op   = gb_bus_pkg::BUS_FETCH;
        cmd_addr = 16'($urandom);
        #1;
        check_value("int_vector", int_vector, 0);
        repeat (4) begin
            next_clock();
            cmd_op = gb_bus_pkg::BUS_IDLE;
            check_value("int_dispatch", int_dispatch, 0);
        end
        int_flags_in = '0;
        int_en       = '0;
    endtask

    task automatic halt_and_stop;
        logic [7:0] key;
        key = 8'(($urandom % 255) + 1);    // Never zero
        wait_cmd_req();
        int_en   = 5'b00100;
        halt_req = 1'b1;
        next_clock();
        halt_req = 1'b0;
        check_value("done", done, 0);
        next_clock();
        check_value("done", done, 1);
        repeat (8) begin
            next_clock();
            check_value("cmd_req", cmd_req, 0);
            check_value("rd", rd, 0);
        end
        int_flags_in = 5'b00100;            // Wake source
        next_clock();
        check_value("done", done, 1);
        next_clock();
        check_value("done", done, 1);
        next_clock();
        check_value("done", done, 0);
        int_flags_in = '0;
        wait_cmd_req();

        stop_req = 1'b1;
        next_clock();
        stop_req = 1'b0;
        next_clock();
        check_value("done", done, 1);
        repeat (8) begin
            next_clock();
            check_value("cmd_req", cmd_req, 0);
        end
        key_in = key;                       // Keypad alone wakes from stop
        next_clock();
        check_value("done", done, 1);
        next_clock();
        check_value("done", done, 1);
        next_clock();
        check_value("done", done, 0);
        key_in = '0;
        wait_cmd_req();
    endtask

    initial begin
        rst          = 1'b1;
        cmd_op       = gb_bus_pkg::BUS_IDLE;
        cmd_addr     = '0;
        cmd_data     = '0;
        cmd_high     = 1'b0;
        din          = '0;
        int_en       = '0;
        int_flags_in = '0;
        ime          = 1'b0;
        int_ack      = 1'b0;
        halt_req     = 1'b0;
        stop_req     = 1'b0;
        key_in       = '0;
        void'($urandom(SEED));
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;

        check_reset_state();
        run_fetch();
        write_high_page();
        read_cycle();
        dispatch_interrupts();
        halt_and_stop();

        $display("Test completed successfully");
        $finish;
    end

endmodule

/* rtl/gb_cpu_bus.sv */
module gb_cpu_bus (
    input  logic                            clk,
    input  logic                            rst,

    // Sequencer command
    input  gb_bus_pkg::bus_op_e             cmd_op,
    input  logic [gb_bus_pkg::ADDR_W-1:0]   cmd_addr,
    input  logic [gb_bus_pkg::DATA_W-1:0]   cmd_data,
    input  logic                            cmd_high,
    output logic                            cmd_req,
    output logic [gb_bus_pkg::DATA_W-1:0]   opcode,
    output logic [gb_bus_pkg::DATA_W-1:0]   rdata,

    // External bus
    input  logic [gb_bus_pkg::DATA_W-1:0]   din,
    output logic [gb_bus_pkg::ADDR_W-1:0]   a,
    output logic [gb_bus_pkg::DATA_W-1:0]   dout,
    output logic                            rd,
    output logic                            wr,
    output logic                            phi,

    // Interrupts
    input  logic [gb_bus_pkg::INT_N-1:0]    int_en,
    input  logic [gb_bus_pkg::INT_N-1:0]    int_flags_in,
    input  logic                            ime,
    input  logic                            int_ack,
    output logic [gb_bus_pkg::INT_N-1:0]    int_flags_out,
    output logic                            int_dispatch,
    output logic [gb_bus_pkg::ADDR_W-1:0]   int_vector,

    // Halt and stop
    input  logic                            halt_req,
    input  logic                            stop_req,
    input  logic [gb_bus_pkg::KEY_W-1:0]    key_in,
    output logic                            done
);

    mcycle_if u_mcycle ();

    bus_cycle_unit u_bus_cycle_unit (
        .clk      (clk),
        .rst      (rst),
        .bus      (u_mcycle.seq),
        .cmd_op   (cmd_op),
        .cmd_addr (cmd_addr),
        .cmd_data (cmd_data),
        .cmd_high (cmd_high),
        .cmd_req  (cmd_req),
        .din      (din),
        .a        (a),
        .dout     (dout),
        .rd       (rd),
        .wr       (wr),
        .phi      (phi),
        .opcode   (opcode),
        .rdata    (rdata)
    );

    int_dispatch u_int_dispatch (
        .clk           (clk),
        .rst           (rst),
        .bus           (u_mcycle.watch),
        .int_en        (int_en),
        .int_flags_in  (int_flags_in),
        .ime           (ime),
        .int_ack       (int_ack),
        .int_flags_out (int_flags_out),
        .int_dispatch  (int_dispatch),
        .int_vector    (int_vector)
    );

    power_ctrl u_power_ctrl (
        .clk          (clk),
        .rst          (rst),
        .bus          (u_mcycle.power),
        .halt_req     (halt_req),
        .stop_req     (stop_req),
        .int_en       (int_en),
        .int_flags_in (int_flags_in),
        .key_in       (key_in),
        .done         (done)
    );

endmodule

/* rtl/power_ctrl.sv */
module power_ctrl (
    input  logic                            clk,
    input  logic                            rst,
    mcycle_if.power                         bus,
    input  logic                            halt_req,
    input  logic                            stop_req,
    input  logic [gb_bus_pkg::INT_N-1:0]    int_en,
    input  logic [gb_bus_pkg::INT_N-1:0]    int_flags_in,
    input  logic [gb_bus_pkg::KEY_W-1:0]    key_in,
    output logic                            done
);

    logic halted;
    logic stopped;
    logic int_wake;     // Enabled request seen without IME
    logic wake_comb;
    logic wake;

    assign int_wake  = |(int_flags_in & int_en);
    assign wake_comb = halted  ? int_wake :
                       stopped ? (int_wake || (|key_in)) : 1'b0;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            halted  <= 1'b0;
            stopped <= 1'b0;
            wake    <= 1'b0;
            done    <= 1'b0;
        end else begin
            wake <= wake_comb;
            done <= halted | stopped;   // One clock behind the state
            if (wake) begin
                halted  <= 1'b0;
                stopped <= 1'b0;
            end else if (!halted && !stopped) begin
                if (halt_req) begin
                    halted <= 1'b1;
                end else if (stop_req) begin
                    stopped <= 1'b1;
                end
            end
        end
    end

    assign bus.hold = halted | stopped;

    a_one_mode: assert property (@(posedge clk) disable iff (rst) !(halted && stopped));

    // A held T0 must run as an idle cycle
    a_hold_idle: assert property (@(posedge clk) disable iff (rst)
        (bus.hold && bus.t_state == gb_bus_pkg::T0) |=> !bus.busy_rd);

endmodule

/* rtl/int_dispatch.sv */
module int_dispatch (
    input  logic                            clk,
    input  logic                            rst,
    mcycle_if.watch                         bus,
    input  logic [gb_bus_pkg::INT_N-1:0]    int_en,
    input  logic [gb_bus_pkg::INT_N-1:0]    int_flags_in,
    input  logic                            ime,
    input  logic                            int_ack,
    output logic [gb_bus_pkg::INT_N-1:0]    int_flags_out,
    output logic                            int_dispatch,
    output logic [gb_bus_pkg::ADDR_W-1:0]   int_vector
);

    logic [gb_bus_pkg::INT_N-1:0]           pending;
    logic [gb_bus_pkg::INT_N-1:0]           sel_bit;    // One-hot of the winner
    logic [$clog2(gb_bus_pkg::INT_N)-1:0]   sel_idx;
    logic                                   sel_valid;

    assign pending = int_flags_in & int_en & {gb_bus_pkg::INT_N{ime}};

    // Lowest index wins, so scan downward and keep the last hit
    always_comb begin
        sel_bit   = '0;
        sel_idx   = '0;
        sel_valid = 1'b0;
        for (int i = gb_bus_pkg::INT_N - 1; i >= 0; i--) begin
            if (pending[i]) begin
                sel_bit    = '0;
                sel_bit[i] = 1'b1;
                sel_idx    = i[$clog2(gb_bus_pkg::INT_N)-1:0];
                sel_valid  = 1'b1;
            end
        end
    end

    // Zero vector when nothing is left to service
    assign int_vector = sel_valid ?
        gb_bus_pkg::INT_VEC_BASE + gb_bus_pkg::INT_VEC_STEP * sel_idx : '0;

    // Serviced request flag drops on acknowledge
    assign int_flags_out = (int_dispatch && int_ack) ? (int_flags_in & ~sel_bit)
                                                     : int_flags_in;

    // Dispatch only starts on an instruction boundary
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            int_dispatch <= 1'b0;
        end else if (int_dispatch && int_ack) begin
            int_dispatch <= 1'b0;
        end else if (!int_dispatch && bus.fetch_done && sel_valid) begin
            int_dispatch <= 1'b1;
        end
    end

    a_ack_in_dispatch: assert property (@(posedge clk) disable iff (rst)
        int_ack |-> int_dispatch);

    // Set at the end of T2, so first seen in T3
    a_rise_at_m_end: assert property (@(posedge clk) disable iff (rst)
        $rose(int_dispatch) |-> bus.m_end);

endmodule

/* rtl/bus_cycle_unit.sv */
module bus_cycle_unit (
    input  logic                            clk,
    input  logic                            rst,
    mcycle_if.seq                           bus,
    input  gb_bus_pkg::bus_op_e             cmd_op,
    input  logic [gb_bus_pkg::ADDR_W-1:0]   cmd_addr,
    input  logic [gb_bus_pkg::DATA_W-1:0]   cmd_data,
    input  logic                            cmd_high,
    output logic                            cmd_req,
    input  logic [gb_bus_pkg::DATA_W-1:0]   din,
    output logic [gb_bus_pkg::ADDR_W-1:0]   a,
    output logic [gb_bus_pkg::DATA_W-1:0]   dout,
    output logic                            rd,
    output logic                            wr,
    output logic                            phi,
    output logic [gb_bus_pkg::DATA_W-1:0]   opcode,
    output logic [gb_bus_pkg::DATA_W-1:0]   rdata
);

    logic [1:0]                     t_cnt;
    gb_bus_pkg::t_state_e           t_state;
    gb_bus_pkg::bus_op_e            req_op;     // Command as seen this T0
    gb_bus_pkg::bus_op_e            op_q;       // Op of the running cycle
    logic [gb_bus_pkg::DATA_W-1:0]  data_q;     // Write data of the cycle

    // Free-running T-state counter
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            t_cnt <= 2'b00;
        end else begin
            t_cnt <= t_cnt + 2'b01;
        end
    end

    assign t_state = gb_bus_pkg::t_state_e'(t_cnt);

    // New command only at T0, and not while suspended
    assign cmd_req = (t_state == gb_bus_pkg::T0) && !bus.hold;
    assign req_op  = cmd_req ? cmd_op : gb_bus_pkg::BUS_IDLE;

    ////////////////////////////////////////////////////////////////////////////
    // External bus sequencing
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            a      <= '0;
            rd     <= 1'b0;
            wr     <= 1'b0;
            dout   <= '0;
            phi    <= 1'b1;
            opcode <= '0;
            rdata  <= '0;
            op_q   <= gb_bus_pkg::BUS_IDLE;
        end else begin
            case (t_state)
                gb_bus_pkg::T0: begin
                    a    <= cmd_high ? {gb_bus_pkg::HIGH_PAGE, cmd_addr[7:0]} : cmd_addr;
                    rd   <= (req_op == gb_bus_pkg::BUS_FETCH) ||
                            (req_op == gb_bus_pkg::BUS_READ);
                    wr   <= 1'b0;
                    phi  <= 1'b1;
                    op_q <= req_op;
                end
                gb_bus_pkg::T1: begin
                    // Memory read in flight
                end
                gb_bus_pkg::T2: begin
                    case (op_q)
                        gb_bus_pkg::BUS_FETCH: opcode <= din;
                        gb_bus_pkg::BUS_READ:  rdata  <= din;
                        gb_bus_pkg::BUS_WRITE: begin
                            wr   <= 1'b1;
                            dout <= data_q;
                        end
                        default: ;
                    endcase
                    rd  <= 1'b0;
                    phi <= 1'b0;
                end
                gb_bus_pkg::T3: begin
                    rd   <= 1'b0;   // Bus idle until next T0
                    wr   <= 1'b0;
                    dout <= '0;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (t_state == gb_bus_pkg::T0) begin
            data_q <= cmd_data;
        end
    end

    // Timing events for the rest of the core
    assign bus.t_state    = t_state;
    assign bus.fetch_done = (t_state == gb_bus_pkg::T2) && (op_q == gb_bus_pkg::BUS_FETCH);
    assign bus.m_end      = (t_state == gb_bus_pkg::T3);
    assign bus.busy_rd    = rd;

    a_rd_wr_excl: assert property (@(posedge clk) disable iff (rst) !(rd && wr));

    // Commands are spaced one machine cycle apart
    a_req_spacing: assert property (@(posedge clk) disable iff (rst)
        cmd_req |=> !cmd_req [*3]);

endmodule

/* rtl/mcycle_if.sv */
interface mcycle_if;

    gb_bus_pkg::t_state_e t_state;   // Current T-state
    logic fetch_done;                // Opcode captured this clock
    logic m_end;                     // Last clock of the machine cycle
    logic busy_rd;                   // rd line is high
    logic hold;                      // Suspend new bus commands

    // Bus engine side
    modport seq (
        output t_state, fetch_done, m_end, busy_rd,
        input  hold
    );

    // Observers of the machine cycle
    modport watch (
        input t_state, fetch_done, m_end, busy_rd
    );

    // Halt/stop control drives hold
    modport power (
        input  t_state, fetch_done, m_end, busy_rd,
        output hold
    );

endinterface

/* rtl/gb_bus_pkg.sv */
package gb_bus_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Bus and port widths
    ////////////////////////////////////////////////////////////////////////////

    localparam int ADDR_W = 16;
    localparam int DATA_W = 8;
    localparam int INT_N  = 5;   // VBlank, LCD STAT, timer, serial, joypad
    localparam int KEY_W  = 8;

    // Upper address byte for the FF00 I/O and HRAM page
    localparam logic [DATA_W-1:0] HIGH_PAGE = 8'hFF;

    // Interrupt vectors sit at 0040, 0048, ... 0060
    localparam logic [ADDR_W-1:0] INT_VEC_BASE = 16'h0040;
    localparam logic [ADDR_W-1:0] INT_VEC_STEP = 16'h0008;

    ////////////////////////////////////////////////////////////////////////////
    // Machine cycle encodings
    ////////////////////////////////////////////////////////////////////////////

    // Clock position inside one machine cycle
    typedef enum logic [1:0] {
        T0 = 2'b00,   // Address setup
        T1 = 2'b01,   // Read in progress
        T2 = 2'b10,   // Data capture / write strobe
        T3 = 2'b11    // Bus released
    } t_state_e;

    // Kind of bus cycle requested by the sequencer
    typedef enum logic [1:0] {
        BUS_IDLE  = 2'b00,
        BUS_FETCH = 2'b01,
        BUS_WRITE = 2'b10,
        BUS_READ  = 2'b11
    } bus_op_e;

endpackage
